// ==== verilog/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address and data width of the core and the bus
`define XLEN 32

// words per cache line, as a power of two
`define ICACHE_LINE_WORDS_LOG2 4

// number of line slots, as a power of two
`define ICACHE_LINES_LOG2 4

// total cached words, lines times words per line
`define ICACHE_WORDS_LOG2 (`ICACHE_LINE_WORDS_LOG2 + `ICACHE_LINES_LOG2)

// tag covers address bits above the line offset and the byte offset
`define ICACHE_TAG_W (`XLEN - `ICACHE_LINE_WORDS_LOG2 - 2)

`endif

// ==== verilog/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

  // byte address as seen by the fetch port
  typedef logic [`XLEN-1:0] addr_t;
  // data word on the bus
  typedef logic [`XLEN-1:0] word_t;
  // fetched instruction
  typedef logic [`XLEN-1:0] instr_t;
  // word address on the wishbone bus
  typedef logic [`XLEN-3:0] wb_adr_t;
  // line tag
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  // line slot index
  typedef logic [`ICACHE_LINES_LOG2-1:0] slot_t;
  // word within a line
  typedef logic [`ICACHE_LINE_WORDS_LOG2-1:0] word_sel_t;
  // block RAM address, slot in the upper bits
  typedef logic [`ICACHE_WORDS_LOG2-1:0] ram_addr_t;

  // refill sequencer states
  typedef enum logic [2:0] {
    FILL_IDLE,
    FILL_REQ,
    FILL_READ,
    FILL_DONE,
    FILL_ABORT
  } fill_state_t;

endpackage

// ==== verilog/bram_dual.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module bram_dual (
  input  logic                  clk_i,
  input  logic                  write_i,
  input  icache_pkg::ram_addr_t waddr_i,
  input  icache_pkg::ram_addr_t raddr_i,
  input  icache_pkg::word_t     data_i,
  output icache_pkg::word_t     data_o
);

  import icache_pkg::*;

  word_t mem [0:(1 << `ICACHE_WORDS_LOG2)-1];

  // write port, one word per cycle
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // read data appears one cycle after the address
  always_ff @(posedge clk_i) begin
    data_o <= mem[raddr_i];
  end

endmodule

// ==== verilog/icache_tag_store.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_tag_store (
  input  logic              clk_i,
  input  logic              reset_i,
  input  icache_pkg::tag_t  lookup_tag_i,
  output logic              hit_o,
  output icache_pkg::slot_t hit_slot_o,
  input  logic              validate_i,
  input  icache_pkg::tag_t  fill_tag_i,
  output icache_pkg::slot_t victim_slot_o
);

  import icache_pkg::*;

  tag_t                               tags_q [0:(1 << `ICACHE_LINES_LOG2)-1];
  logic [(1 << `ICACHE_LINES_LOG2)-1:0] valid_q;
  slot_t                              victim_q;

  // fully associative compare against every valid slot
  always_comb begin
    hit_o      = 1'b0;
    hit_slot_o = '0;
    for (int i = 0; i < (1 << `ICACHE_LINES_LOG2); i++) begin
      if (valid_q[i] && (tags_q[i] == lookup_tag_i)) begin
        hit_o      = 1'b1;
        hit_slot_o = slot_t'(i);
      end
    end
  end

  // valid bits and the round-robin pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (validate_i) begin
      valid_q[victim_q] <= 1'b1;
      // next refill goes to the following slot
      victim_q <= victim_q + 1'b1;
    end
  end

  // tag of the freshly filled line
  always_ff @(posedge clk_i) begin
    if (validate_i) begin
      tags_q[victim_q] <= fill_tag_i;
    end
  end

  assign victim_slot_o = victim_q;

endmodule

// ==== verilog/icache_fill.sv ====
`timescale 1ns/1ns

module icache_fill (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  icache_pkg::tag_t    line_addr_i,
  input  icache_pkg::slot_t   victim_slot_i,
  output logic                fill_req_o,
  input  logic                fill_gnt_i,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output icache_pkg::wb_adr_t wb_adr_o,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  output logic                ram_we_o,
  output icache_pkg::ram_addr_t ram_waddr_o,
  output logic                active_o,
  output logic                done_o,
  output logic                abort_o
);

  import icache_pkg::*;

  fill_state_t state_q;
  tag_t        line_q;
  slot_t       slot_q;
  word_sel_t   word_q;
  logic        cyc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FILL_IDLE;
      word_q  <= '0;
      cyc_q   <= 1'b0;
    end else begin
      case (state_q)
        FILL_IDLE: begin
          if (start_i) begin
            word_q  <= '0;
            state_q <= FILL_REQ;
          end
        end
        FILL_REQ: begin
          // wait until the arbiter hands the bus over
          if (fill_gnt_i) begin
            cyc_q   <= 1'b1;
            state_q <= FILL_READ;
          end
        end
        FILL_READ: begin
          if (wb_err_i) begin
            cyc_q   <= 1'b0;
            state_q <= FILL_ABORT;
          end else if (wb_ack_i) begin
            word_q <= word_q + 1'b1;
            // last word of the line closes the bus cycle
            if (word_q == '1) begin
              cyc_q   <= 1'b0;
              state_q <= FILL_DONE;
            end
          end
        end
        FILL_DONE: begin
          state_q <= FILL_IDLE;
        end
        FILL_ABORT: begin
          state_q <= FILL_IDLE;
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
    end
  end

  // line and slot are captured when the refill starts
  always_ff @(posedge clk_i) begin
    if ((state_q == FILL_IDLE) && start_i) begin
      line_q <= line_addr_i;
      slot_q <= victim_slot_i;
    end
  end

  // request drops in DONE or ABORT, the grant follows a cycle later
  assign fill_req_o = (state_q == FILL_REQ) || (state_q == FILL_READ);

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = {line_q, word_q};

  // every ack delivers one word for the block RAM
  assign ram_we_o    = (state_q == FILL_READ) && wb_ack_i && !wb_err_i;
  assign ram_waddr_o = {slot_q, word_q};

  assign active_o = (state_q != FILL_IDLE);
  assign done_o   = (state_q == FILL_DONE);
  assign abort_o  = (state_q == FILL_ABORT);

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fetch_advance_i,
  input  icache_pkg::addr_t   fetch_addr_i,
  output logic                fetch_busy_o,
  output icache_pkg::instr_t  fetch_instr_o,
  output logic                fetch_fault_o,
  output logic                fill_req_o,
  input  logic                fill_gnt_i,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output icache_pkg::wb_adr_t wb_adr_o,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  input  icache_pkg::word_t   wb_dat_i
);

  import icache_pkg::*;

  tag_t      lookup_tag;
  word_sel_t lookup_word;
  logic      misaligned;
  logic      tag_hit;
  slot_t     hit_slot;
  slot_t     victim_slot;
  logic      hit;
  logic      miss;
  logic      start;
  logic      accept;
  logic      fill_active;
  logic      fill_done;
  logic      fill_abort;
  logic      ram_we;
  ram_addr_t ram_waddr;
  word_t     ram_q;
  logic      victim_stale_q;
  logic      abort_pending_q;
  logic      accepted_q;
  logic      fault_q;
  instr_t    instr_hold_q;

  assign lookup_tag  = fetch_addr_i[`XLEN-1:`XLEN-`ICACHE_TAG_W];
  assign lookup_word = fetch_addr_i[`ICACHE_LINE_WORDS_LOG2+1:2];
  assign misaligned  = |fetch_addr_i[1:0];

  // the victim slot's old line is overwritten from the first refill write on
  assign hit = tag_hit && !(victim_stale_q && (hit_slot == victim_slot));

  // an aborted refill is answered with a fault instead of a retry
  assign miss  = fetch_advance_i && !misaligned && !hit && !abort_pending_q;
  assign start = miss && !fill_active;

  assign fetch_busy_o = fill_active || miss;
  assign accept       = fetch_advance_i && !fetch_busy_o;

  icache_tag_store u_tag_store (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_tag_i  (lookup_tag),
    .hit_o         (tag_hit),
    .hit_slot_o    (hit_slot),
    .validate_i    (fill_done),
    .fill_tag_i    (lookup_tag),
    .victim_slot_o (victim_slot)
  );

  icache_fill u_fill (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (start),
    .line_addr_i   (lookup_tag),
    .victim_slot_i (victim_slot),
    .fill_req_o    (fill_req_o),
    .fill_gnt_i    (fill_gnt_i),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .ram_we_o      (ram_we),
    .ram_waddr_o   (ram_waddr),
    .active_o      (fill_active),
    .done_o        (fill_done),
    .abort_o       (fill_abort)
  );

  bram_dual u_bram (
    .clk_i   (clk_i),
    .write_i (ram_we),
    .waddr_i (ram_waddr),
    .raddr_i ({hit_slot, lookup_word}),
    .data_i  (wb_dat_i),
    .data_o  (ram_q)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_stale_q  <= 1'b0;
      abort_pending_q <= 1'b0;
      accepted_q      <= 1'b0;
      fault_q         <= 1'b0;
    end else begin
      if (start) begin
        victim_stale_q <= 1'b1;
      end else if (fill_done) begin
        victim_stale_q <= 1'b0;
      end
      if (fill_abort) begin
        abort_pending_q <= 1'b1;
      end else if (accept) begin
        abort_pending_q <= 1'b0;
      end
      accepted_q <= accept;
      if (accept) begin
        fault_q <= misaligned || abort_pending_q;
      end
    end
  end

  // keeps the last instruction while no fetch is accepted
  always_ff @(posedge clk_i) begin
    instr_hold_q <= fetch_instr_o;
  end

  assign fetch_instr_o = accepted_q ? ram_q : instr_hold_q;
  assign fetch_fault_o = fault_q;

endmodule

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module wb_arbiter (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   fill_req_i,
  output logic                   fill_gnt_o,
  input  logic                   icache_cyc_i,
  input  logic                   icache_stb_i,
  input  icache_pkg::wb_adr_t    icache_adr_i,
  output logic                   icache_ack_o,
  output logic                   icache_err_o,
  output icache_pkg::word_t      icache_dat_o,
  input  logic                   dbus_cyc_i,
  input  logic                   dbus_stb_i,
  input  icache_pkg::wb_adr_t    dbus_adr_i,
  input  logic                   dbus_we_i,
  input  logic [`XLEN/8-1:0]     dbus_sel_i,
  input  icache_pkg::word_t      dbus_dat_i,
  output logic                   dbus_ack_o,
  output logic                   dbus_err_o,
  output icache_pkg::word_t      dbus_dat_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output icache_pkg::wb_adr_t    wb_adr_o,
  output logic                   wb_we_o,
  output logic [`XLEN/8-1:0]     wb_sel_o,
  output icache_pkg::word_t      wb_dat_o,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i,
  input  icache_pkg::word_t      wb_dat_i
);

  logic fill_gnt_q;
  logic dbus_gnt;

  // owner changes only while the bus is idle, data port first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_gnt_q <= 1'b0;
      dbus_gnt   <= 1'b0;
    end else if (!fill_gnt_q && !dbus_gnt) begin
      if (dbus_cyc_i) begin
        dbus_gnt <= 1'b1;
      end else if (fill_req_i) begin
        fill_gnt_q <= 1'b1;
      end
    end else if (dbus_gnt && !dbus_cyc_i) begin
      dbus_gnt <= 1'b0;
    end else if (fill_gnt_q && !fill_req_i) begin
      fill_gnt_q <= 1'b0;
    end
  end

  assign fill_gnt_o = fill_gnt_q;

  // bus outputs follow the owner, icache reads use fixed we and sel
  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_adr_o = '0;
    wb_we_o  = 1'b0;
    wb_sel_o = '0;
    wb_dat_o = '0;
    if (dbus_gnt) begin
      wb_cyc_o = dbus_cyc_i;
      wb_stb_o = dbus_stb_i;
      wb_adr_o = dbus_adr_i;
      wb_we_o  = dbus_we_i;
      wb_sel_o = dbus_sel_i;
      wb_dat_o = dbus_dat_i;
    end else if (fill_gnt_q) begin
      wb_cyc_o = icache_cyc_i;
      wb_stb_o = icache_stb_i;
      wb_adr_o = icache_adr_i;
      wb_sel_o = '1;
    end
  end

  // responses reach the owning master only
  assign dbus_ack_o   = dbus_gnt && wb_ack_i;
  assign dbus_err_o   = dbus_gnt && wb_err_i;
  assign dbus_dat_o   = dbus_gnt ? wb_dat_i : '0;
  assign icache_ack_o = fill_gnt_q && wb_ack_i;
  assign icache_err_o = fill_gnt_q && wb_err_i;
  assign icache_dat_o = fill_gnt_q ? wb_dat_i : '0;

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fetch_advance_i,
  input  icache_pkg::addr_t   fetch_addr_i,
  output logic                fetch_busy_o,
  output icache_pkg::instr_t  fetch_instr_o,
  output logic                fetch_fault_o,
  input  logic                dbus_cyc_i,
  input  logic                dbus_stb_i,
  input  icache_pkg::wb_adr_t dbus_adr_i,
  input  logic                dbus_we_i,
  input  logic [`XLEN/8-1:0]  dbus_sel_i,
  input  icache_pkg::word_t   dbus_dat_i,
  output logic                dbus_ack_o,
  output logic                dbus_err_o,
  output icache_pkg::word_t   dbus_dat_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output icache_pkg::wb_adr_t wb_adr_o,
  output logic                wb_we_o,
  output logic [`XLEN/8-1:0]  wb_sel_o,
  output icache_pkg::word_t   wb_dat_o,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  input  icache_pkg::word_t   wb_dat_i
);

  import icache_pkg::*;

  logic    fill_req;
  logic    fill_gnt;
  logic    icache_cyc;
  logic    icache_stb;
  wb_adr_t icache_adr;
  logic    icache_ack;
  logic    icache_err;
  word_t   icache_dat;

  icache u_icache (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_advance_i (fetch_advance_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_busy_o    (fetch_busy_o),
    .fetch_instr_o   (fetch_instr_o),
    .fetch_fault_o   (fetch_fault_o),
    .fill_req_o      (fill_req),
    .fill_gnt_i      (fill_gnt),
    .wb_cyc_o        (icache_cyc),
    .wb_stb_o        (icache_stb),
    .wb_adr_o        (icache_adr),
    .wb_ack_i        (icache_ack),
    .wb_err_i        (icache_err),
    .wb_dat_i        (icache_dat)
  );

  wb_arbiter u_arbiter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fill_req_i   (fill_req),
    .fill_gnt_o   (fill_gnt),
    .icache_cyc_i (icache_cyc),
    .icache_stb_i (icache_stb),
    .icache_adr_i (icache_adr),
    .icache_ack_o (icache_ack),
    .icache_err_o (icache_err),
    .icache_dat_o (icache_dat),
    .dbus_cyc_i   (dbus_cyc_i),
    .dbus_stb_i   (dbus_stb_i),
    .dbus_adr_i   (dbus_adr_i),
    .dbus_we_i    (dbus_we_i),
    .dbus_sel_i   (dbus_sel_i),
    .dbus_dat_i   (dbus_dat_i),
    .dbus_ack_o   (dbus_ack_o),
    .dbus_err_o   (dbus_err_o),
    .dbus_dat_o   (dbus_dat_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_we_o      (wb_we_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i),
    .wb_dat_i     (wb_dat_i)
  );

endmodule

// ==== verification/icache_checker.sv ====
`timescale 1ns/1ns

module icache_checker (
  input logic clk_i,
  input logic reset_i,
  input logic cyc_i,
  input logic stb_i,
  input logic fill_req_i,
  input logic fill_gnt_i,
  input logic dbus_gnt_i
);

  // classic cycle: strobe only inside a bus cycle
  stb_within_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    stb_i |-> cyc_i)
    else $error("wishbone stb high while cyc is low");

  // one owner at a time
  single_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_gnt_i && dbus_gnt_i))
    else $error("both masters hold a grant");

  // four-phase request stays up until granted
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_req_i && !fill_gnt_i) |=> fill_req_i)
    else $error("fill request dropped before its grant");

endmodule

bind wb_arbiter icache_checker u_checker (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .fill_req_i (fill_req_i),
  .fill_gnt_i (fill_gnt_q),
  .dbus_gnt_i (dbus_gnt)
);

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb;

  import icache_pkg::*;

  localparam int    CLK_HALF  = 50;
  localparam int    DRIVE_DLY = 1;
  localparam int    RESP_DLY  = 2;
  localparam int    TIMEOUT   = 200;
  localparam addr_t LINE_BASE = 32'h0000_1000;
  localparam addr_t ERR_LINE  = 32'h0000_8000;
  localparam tag_t  ERR_TAG   = ERR_LINE[31:6];

  logic       clk_i;
  logic       reset_i;
  logic       fetch_advance_i;
  addr_t      fetch_addr_i;
  logic       fetch_busy_o;
  instr_t     fetch_instr_o;
  logic       fetch_fault_o;
  logic       dbus_cyc_i;
  logic       dbus_stb_i;
  wb_adr_t    dbus_adr_i;
  logic       dbus_we_i;
  logic [3:0] dbus_sel_i;
  word_t      dbus_dat_i;
  logic       dbus_ack_o;
  logic       dbus_err_o;
  word_t      dbus_dat_o;
  logic       wb_cyc_o;
  logic       wb_stb_o;
  wb_adr_t    wb_adr_o;
  logic       wb_we_o;
  logic [3:0] wb_sel_o;
  word_t      wb_dat_o;
  logic       wb_ack_i;
  logic       wb_err_i;
  word_t      wb_dat_i;

  logic [31:0] lfsr;
  int          waits_left;
  int          err_count;
  int          timeout_count;
  wb_adr_t     adr_q[$];
  logic        we_q[$];
  logic [3:0]  sel_q[$];

  icache_top u_dut (.*);

  always #(CLK_HALF) clk_i = ~clk_i;

  // fibonacci LFSR with taps 32 22 2 1
  function automatic bit next_bit();
    bit fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // reference memory contents as a fixed mix of the word address
  function automatic word_t mem_word(wb_adr_t a);
    logic [31:0] x;
    x = {2'b00, a};
    return (x * 32'h9e37_79b1) ^ {x[15:0], x[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  task automatic check_instr(string name, instr_t got, instr_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(string name, bit got, bit exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // wishbone slave with 0 to 3 wait cycles and err on one line
  always begin
    @(posedge clk_i);
    #(RESP_DLY);
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    if (wb_cyc_o && wb_stb_o) begin
      if (waits_left < 0) begin
        waits_left = 2 * int'(next_bit());
        waits_left = waits_left + int'(next_bit());
      end
      if (waits_left == 0) begin
        if (wb_adr_o[29:4] == ERR_TAG) begin
          wb_err_i = 1'b1;
        end else begin
          wb_ack_i = 1'b1;
          wb_dat_i = mem_word(wb_adr_o);
        end
        waits_left = -1;
      end else begin
        waits_left--;
      end
    end else begin
      waits_left = -1;
    end
  end

  // record every finished bus transfer
  always @(negedge clk_i) begin
    if (wb_cyc_o && wb_stb_o && (wb_ack_i || wb_err_i)) begin
      adr_q.push_back(wb_adr_o);
      we_q.push_back(wb_we_o);
      sel_q.push_back(wb_sel_o);
    end
  end

  // holds the advance until accepted and returns the result of the next cycle
  task automatic do_fetch(input addr_t a, output instr_t instr, output bit fault,
                          output int xfers, output bit busy_seen);
    int n0;
    int cycles;
    n0 = adr_q.size();
    busy_seen = 1'b0;
    cycles = 0;
    fetch_addr_i = a;
    fetch_advance_i = 1'b1;
    @(negedge clk_i);
    while (fetch_busy_o && cycles < TIMEOUT) begin
      busy_seen = 1'b1;
      cycles++;
      @(negedge clk_i);
    end
    if (fetch_busy_o) begin
      $display("timeout: fetch of %h was never accepted", a);
      timeout_count++;
    end
    @(posedge clk_i);
    #(DRIVE_DLY);
    fetch_advance_i = 1'b0;
    @(negedge clk_i);
    instr = fetch_instr_o;
    fault = fetch_fault_o;
    xfers = adr_q.size() - n0;
    @(posedge clk_i);
    #(DRIVE_DLY);
  endtask

  // data port read that also reports whether the slave raised err
  task automatic dbus_read(input wb_adr_t a, output word_t data, output bit err);
    int cycles;
    cycles = 0;
    dbus_adr_i = a;
    dbus_we_i  = 1'b0;
    dbus_sel_i = 4'hf;
    // marker pattern on the write data lines
    dbus_dat_i = {2'b10, a};
    dbus_cyc_i = 1'b1;
    dbus_stb_i = 1'b1;
    @(negedge clk_i);
    while (!(dbus_ack_o || dbus_err_o) && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!(dbus_ack_o || dbus_err_o)) begin
      $display("timeout: data port read of %h got neither ack nor err", a);
      timeout_count++;
    end
    check_word("wb_dat_o", wb_dat_o, {2'b10, a});
    data = dbus_dat_o;
    err  = dbus_err_o;
    @(posedge clk_i);
    #(DRIVE_DLY);
    dbus_cyc_i = 1'b0;
    dbus_stb_i = 1'b0;
  endtask

  task automatic fetch_and_check(string name, addr_t a, bit exp_fault, int exp_xfers);
    instr_t instr;
    bit     fault;
    int     xfers;
    bit     busy_seen;
    do_fetch(a, instr, fault, xfers, busy_seen);
    check_flag({name, " fetch_fault_o"}, fault, exp_fault);
    if (!exp_fault) begin
      check_instr({name, " fetch_instr_o"}, instr, mem_word(a[31:2]));
    end
    if (exp_xfers >= 0) begin
      check_word({name, " bus transfers"}, word_t'(xfers), word_t'(exp_xfers));
    end
    if (exp_xfers == 0) begin
      check_flag({name, " fetch_busy_o"}, busy_seen, 1'b0);
    end
  endtask

  initial begin
    int    n0;
    int    pos;
    word_t dword;
    bit    derr;
    clk_i = 1'b0;
    reset_i = 1'b1;
    fetch_advance_i = 1'b0;
    fetch_addr_i = '0;
    dbus_cyc_i = 1'b0;
    dbus_stb_i = 1'b0;
    dbus_adr_i = '0;
    dbus_we_i = 1'b0;
    dbus_sel_i = '0;
    dbus_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_dat_i = '0;
    lfsr = 32'h2759e457;
    waits_left = -1;
    err_count = 0;
    timeout_count = 0;
    repeat (2) @(posedge clk_i);
    #(DRIVE_DLY);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_flag("fetch_busy_o after reset", fetch_busy_o, 1'b0);
    check_flag("wb_cyc_o after reset", wb_cyc_o, 1'b0);
    check_flag("wb_stb_o after reset", wb_stb_o, 1'b0);
    check_flag("dbus_ack_o after reset", dbus_ack_o, 1'b0);
    @(posedge clk_i);
    #(DRIVE_DLY);

    // cold miss fills line 0 from its base upwards
    n0 = adr_q.size();
    fetch_and_check("cold miss", LINE_BASE + 12, 1'b0, 16);
    for (int k = 0; k < 16 && n0 + k < adr_q.size(); k++) begin
      check_word("wb_adr_o refill", word_t'(adr_q[n0 + k]), word_t'(LINE_BASE[31:2] + k));
      check_flag("wb_we_o refill", we_q[n0 + k], 1'b0);
      check_word("wb_sel_o refill", word_t'(sel_q[n0 + k]), 32'hf);
    end

    fetch_and_check("hit w1", LINE_BASE + 4, 1'b0, 0);
    fetch_and_check("hit w15", LINE_BASE + 60, 1'b0, 0);
    fetch_and_check("hit w0", LINE_BASE, 1'b0, 0);

    // lines 1 to 16 where the last one evicts line 0
    for (int k = 1; k <= 16; k++) begin
      fetch_and_check("fill", LINE_BASE + 64 * k + 4 * (k % 16), 1'b0, 16);
    end
    fetch_and_check("line 1 still cached", LINE_BASE + 64 + 8, 1'b0, 0);
    fetch_and_check("line 0 evicted", LINE_BASE + 20, 1'b0, 16);

    // bus error aborts the refill and a retry refills again
    fetch_and_check("bus error", ERR_LINE + 8, 1'b1, 1);
    fetch_and_check("bus error retry", ERR_LINE + 8, 1'b1, 1);

    fetch_and_check("misaligned", LINE_BASE + 2, 1'b1, 0);

    // data port read while a refill holds the bus
    n0 = adr_q.size();
    fork
      fetch_and_check("fetch with dbus", LINE_BASE + 64 * 20 + 28, 1'b0, -1);
      begin
        pos = 0;
        while (!wb_cyc_o && pos < TIMEOUT) begin
          pos++;
          @(negedge clk_i);
        end
        if (!wb_cyc_o) begin
          $display("timeout: refill never started a bus cycle");
          timeout_count++;
        end
        @(posedge clk_i);
        #(DRIVE_DLY);
        dbus_read(30'h0100_0040, dword, derr);
      end
    join
    check_word("dbus_dat_o", dword, mem_word(30'h0100_0040));
    check_flag("dbus_err_o", derr, 1'b0);
    pos = -1;
    for (int k = n0; k < adr_q.size(); k++) begin
      if (adr_q[k] == 30'h0100_0040) begin
        pos = k - n0;
      end
    end
    check_word("dbus transfer position", word_t'(pos), 32'd16);

    // data port read of the error line ends with err
    dbus_read(ERR_LINE[31:2] + 30'd3, dword, derr);
    check_flag("dbus_err_o on error line", derr, 1'b1);

    $display("errors: %0d value mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== icache.f ====
+incdir+verilog
verilog/icache_pkg.sv
verilog/bram_dual.sv
verilog/icache_tag_store.sv
verilog/icache_fill.sv
verilog/icache.sv
verilog/wb_arbiter.sv
verilog/icache_top.sv
verification/icache_checker.sv
verification/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
  -f icache.f --top-module icache_tb -o icache_sim > build.log 2>&1 \
  && ./obj_dir/icache_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }

exit 0
